/* flist.f */
common/pkt_buf_pkg.sv
design/buffer_allocator.sv
design/packet_buffer_mem.sv
packet_write/packet_write.sv
design/packet_buffer_top.sv
testbench/tb_clock_gen.sv
testbench/packet_buffer_tb.sv

/* testbench/packet_buffer_tb.sv */
module packet_buffer_tb;
    import pkt_buf_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam bit DROP_ERRORED = 1'b1;

    logic                clk;
    logic                arst_n;
    logic                in_valid;
    pkt_beat_t           in_beat;
    logic                in_rdy;
    logic                desc_valid;
    pkt_desc_t           desc;
    logic                evt_valid;
    pkt_event_t          evt;
    logic [ADDR_WID-1:0] rd_addr;
    logic [DATA_WID-1:0] rd_data;

    // Model of the ring head and the last kept packet
    int                  model_head;
    int                  last_addr;
    logic [DATA_WID-1:0] pkt_data [64];
    int                  error_cnt;
    int                  timeout_cnt;

    tb_clock_gen i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    packet_buffer_top #(
        .DROP_ERRORED (DROP_ERRORED)
    ) i_packet_buffer_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_rdy     (in_rdy),
        .desc_valid (desc_valid),
        .desc       (desc),
        .evt_valid  (evt_valid),
        .evt        (evt),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // ====================
    // Helpers
    // ====================

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        error_cnt++;
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    function automatic int words_of(input int size);
        return (size + DATA_BYTES - 1) / DATA_BYTES;
    endfunction

    function automatic int rand_size();
        return MIN_PKT_SIZE + int'($urandom % (MAX_PKT_SIZE - MIN_PKT_SIZE + 1));
    endfunction

    // Status in priority order of short, long, overflow and error
    function automatic pkt_status_t expected_status(input int size, input logic err);
        int slot_len;
        slot_len = BUFFER_WORDS - model_head;
        if (slot_len > SLOT_WORDS)
        begin
            slot_len = SLOT_WORDS;
        end
        if (size < MIN_PKT_SIZE)
            return STATUS_SHORT;
        if (size > MAX_PKT_SIZE)
            return STATUS_LONG;
        if (words_of(size) > slot_len)
            return STATUS_OFLOW;
        if (err)
            return STATUS_ERR;
        return STATUS_OK;
    endfunction

    task automatic wait_rdy();
        int cnt;
        cnt = 0;
        while (!in_rdy && cnt < WAIT_LIMIT)
        begin
            @(negedge clk);
            cnt++;
        end
        if (!in_rdy)
        begin
            timeout_cnt++;
            $display("Timeout: in_rdy stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Leaves the last beat driven and returns in the completion cycle
    task automatic send_packet(input int size, input logic err, input logic [31:0] meta);
        int beats;
        beats = words_of(size);
        for (int i = 0; i < beats; i++)
        begin
            pkt_data[i]  = {$urandom, $urandom};
            in_valid     = 1'b1;
            in_beat.data = pkt_data[i];
            in_beat.eop  = (i == beats - 1);
            in_beat.mty  = (i == beats - 1) ? 3'(beats * DATA_BYTES - size) : 3'd0;
            in_beat.err  = (i == beats - 1) ? err : 1'b0;
            in_beat.meta = (i == beats - 1) ? meta : 32'd0;
            wait_rdy();
            @(negedge clk);
        end
    endtask

    task automatic check_completion(input int size, input pkt_status_t exp_status,
                                    input logic [31:0] meta);
        int   lat;
        logic keep;
        lat  = 1;
        keep = (exp_status == STATUS_OK) || ((exp_status == STATUS_ERR) && !DROP_ERRORED);
        while (!evt_valid && lat < WAIT_LIMIT)
        begin
            @(negedge clk);
            lat++;
        end
        if (!evt_valid)
        begin
            timeout_cnt++;
            $display("Timeout: no completion event within %0d cycles", WAIT_LIMIT);
        end
        else
        begin
            if (lat != 1)
            begin
                error_cnt++;
                $display("Event came %0d cycles after eop instead of 1", lat);
            end
            if (evt.status !== exp_status)
                report_mismatch("evt.status", evt.status, exp_status);
            if (evt.size !== SIZE_WID'(size))
                report_mismatch("evt.size", evt.size, size);
            if (desc_valid !== keep)
                report_mismatch("desc_valid", desc_valid, keep);
            if (keep && desc.addr !== ADDR_WID'(model_head))
                report_mismatch("desc.addr", desc.addr, model_head);
            if (keep && desc.size !== SIZE_WID'(size))
                report_mismatch("desc.size", desc.size, size);
            if (keep && desc.meta !== meta)
                report_mismatch("desc.meta", desc.meta, meta);
        end
        // Head moves on kept packets and wraps on overflow
        if (keep)
        begin
            last_addr  = model_head;
            model_head = (model_head + words_of(size)) % BUFFER_WORDS;
        end
        else if (exp_status == STATUS_OFLOW)
        begin
            model_head = 0;
        end
    endtask

    task automatic run_packet(input int size, input logic err, input logic [31:0] meta,
                              output pkt_status_t status);
        status = expected_status(size, err);
        send_packet(size, err, meta);
        check_completion(size, status, meta);
    endtask

    task automatic set_idle();
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic read_back(input int base, input int size);
        for (int i = 0; i < words_of(size); i++)
        begin
            rd_addr = ADDR_WID'((base + i) % BUFFER_WORDS);
            @(negedge clk);
            if (rd_data !== pkt_data[i])
                report_mismatch("rd_data", rd_data, pkt_data[i]);
        end
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_reset();
        int          cnt;
        pkt_status_t st;
        cnt = 0;
        while (arst_n !== 1'b1 && cnt < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (arst_n === 1'b0)
            begin
                if (in_rdy !== 1'b0)
                    report_mismatch("in_rdy", in_rdy, 0);
                if (desc_valid !== 1'b0)
                    report_mismatch("desc_valid", desc_valid, 0);
                if (evt_valid !== 1'b0)
                    report_mismatch("evt_valid", evt_valid, 0);
            end
            cnt++;
        end
        if (arst_n !== 1'b1)
        begin
            timeout_cnt++;
            $display("Timeout: reset was not released within %0d cycles", WAIT_LIMIT);
        end
        wait_rdy();
        run_packet(rand_size(), 1'b0, $urandom, st);
        if (desc.addr !== '0)
            report_mismatch("desc.addr", desc.addr, 0);
        set_idle();
    endtask

    task automatic test_single_good();
        int          size;
        pkt_status_t st;
        size = rand_size();
        run_packet(size, 1'b0, $urandom, st);
        set_idle();
        read_back(last_addr, size);
    endtask

    task automatic test_errored();
        int          head_before;
        pkt_status_t st;
        head_before = model_head;
        run_packet(rand_size(), 1'b1, $urandom, st);
        run_packet(rand_size(), 1'b0, $urandom, st);
        if (desc.addr !== ADDR_WID'(head_before))
            report_mismatch("desc.addr", desc.addr, head_before);
        set_idle();
    endtask

    task automatic test_short_long();
        int          head_before;
        pkt_status_t st;
        head_before = model_head;
        run_packet(MIN_PKT_SIZE - 1, 1'b0, $urandom, st);
        run_packet(MAX_PKT_SIZE + 8, 1'b0, $urandom, st);
        run_packet(rand_size(), 1'b0, $urandom, st);
        if (desc.addr !== ADDR_WID'(head_before))
            report_mismatch("desc.addr", desc.addr, head_before);
        set_idle();
    endtask

    task automatic test_overflow();
        int          guard;
        pkt_status_t st;
        guard = 0;
        // Misalign the head so the tail ends up shorter than a full slot
        if (model_head % SLOT_WORDS == 0)
            run_packet(24, 1'b0, $urandom, st);
        while (BUFFER_WORDS - model_head >= SLOT_WORDS && guard < 32)
        begin
            run_packet(MAX_PKT_SIZE, 1'b0, $urandom, st);
            guard++;
        end
        run_packet(MAX_PKT_SIZE, 1'b0, $urandom, st);
        if (st != STATUS_OFLOW)
        begin
            error_cnt++;
            $display("Overflow test never reached a short ring tail");
        end
        run_packet(rand_size(), 1'b0, $urandom, st);
        if (desc.addr !== '0)
            report_mismatch("desc.addr", desc.addr, 0);
        set_idle();
    endtask

    task automatic test_burst();
        int          size;
        pkt_status_t st;
        size = 0;
        st   = STATUS_OK;
        // in_valid stays high across the bubbles
        for (int n = 0; n < 20; n++)
        begin
            size = rand_size();
            run_packet(size, 1'b0, $urandom, st);
        end
        set_idle();
        if (st == STATUS_OK)
            read_back(last_addr, size);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        void'($urandom(32'hab9e_1449));
        error_cnt   = 0;
        timeout_cnt = 0;
        model_head  = 0;
        last_addr   = 0;
        in_valid    = 1'b0;
        in_beat     = '0;
        rd_addr     = '0;

        test_reset();
        test_single_good();
        test_errored();
        test_short_long();
        test_overflow();
        test_burst();

        $display("Errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // Period of 10
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // Reset held over two rising edges, released on a falling edge
    initial
    begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* design/packet_buffer_top.sv */
module packet_buffer_top #(
    parameter bit DROP_ERRORED = 1'b1
) (
    input  logic                              clk,
    input  logic                              arst_n,

    // Packet stream in
    input  logic                              in_valid,
    input  pkt_buf_pkg::pkt_beat_t            in_beat,
    output logic                              in_rdy,

    // Descriptor and event out
    output logic                              desc_valid,
    output pkt_buf_pkg::pkt_desc_t            desc,
    output logic                              evt_valid,
    output pkt_buf_pkg::pkt_event_t           evt,

    // Buffer read-back
    input  logic [pkt_buf_pkg::ADDR_WID-1:0]  rd_addr,
    output logic [pkt_buf_pkg::DATA_WID-1:0]  rd_data
);
    import pkt_buf_pkg::*;

    slot_t                 slot;
    logic                  commit_valid;
    logic [WORDS_WID-1:0]  commit_words;
    logic                  oflow_valid;

    logic                  wr_en;
    logic [ADDR_WID-1:0]   wr_addr;
    logic [DATA_WID-1:0]   wr_data;

    buffer_allocator i_buffer_allocator (
        .clk          (clk),
        .arst_n       (arst_n),
        .commit_valid (commit_valid),
        .commit_words (commit_words),
        .oflow_valid  (oflow_valid),
        .slot         (slot)
    );

    packet_write #(
        .DROP_ERRORED (DROP_ERRORED)
    ) i_packet_write (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .in_rdy       (in_rdy),
        .slot         (slot),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_words (commit_words),
        .oflow_valid  (oflow_valid),
        .desc_valid   (desc_valid),
        .desc         (desc),
        .evt_valid    (evt_valid),
        .evt          (evt)
    );

    packet_buffer_mem i_packet_buffer_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* packet_write/packet_write.sv */
module packet_write #(
    parameter bit DROP_ERRORED = 1'b1
) (
    input  logic                                 clk,
    input  logic                                 arst_n,

    // Packet stream in
    input  logic                                 in_valid,
    input  pkt_buf_pkg::pkt_beat_t               in_beat,
    output logic                                 in_rdy,

    // Slot from the allocator
    input  pkt_buf_pkg::slot_t                   slot,

    // Memory write port
    output logic                                 wr_en,
    output logic [pkt_buf_pkg::ADDR_WID-1:0]     wr_addr,
    output logic [pkt_buf_pkg::DATA_WID-1:0]     wr_data,

    // Head update to the allocator
    output logic                                 commit_valid,
    output logic [pkt_buf_pkg::WORDS_WID-1:0]    commit_words,
    output logic                                 oflow_valid,

    // Descriptor and completion event
    output logic                                 desc_valid,
    output pkt_buf_pkg::pkt_desc_t               desc,
    output logic                                 evt_valid,
    output pkt_buf_pkg::pkt_event_t              evt
);
    import pkt_buf_pkg::*;

    logic                  accept;
    logic                  eop_accept;
    logic [SIZE_WID-1:0]   byte_cnt;
    logic [SIZE_WID-4:0]   word_idx;
    logic [SIZE_WID-4:0]   word_cnt;
    logic                  slot_full;
    logic [SIZE_WID-1:0]   eop_size;
    pkt_status_t           status_d;
    logic                  keep_d;

    assign accept     = in_valid && in_rdy;
    assign eop_accept = accept && in_beat.eop;

    // Byte count of full beats so far; word index is its upper part
    assign word_idx = byte_cnt[SIZE_WID-1:3];
    assign word_cnt = word_idx + 1'b1;

    // Final size including the eop beat
    assign eop_size = byte_cnt + SIZE_WID'(DATA_BYTES) - SIZE_WID'(in_beat.mty);

    // ====================
    // Memory write
    // ====================

    // Beats past the slot end are dropped on the floor
    assign wr_en   = accept && !slot_full;
    assign wr_addr = slot.addr + word_idx[ADDR_WID-1:0];
    assign wr_data = in_beat.data;

    // ====================
    // Length tracking
    // ====================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            byte_cnt  <= '0;
            slot_full <= 1'b0;
        end
        else if (accept)
        begin
            if (in_beat.eop)
            begin
                byte_cnt  <= '0;
                slot_full <= 1'b0;
            end
            else
            begin
                // Saturate once past the max size
                if (byte_cnt <= SIZE_WID'(MAX_PKT_SIZE))
                begin
                    byte_cnt <= byte_cnt + SIZE_WID'(DATA_BYTES);
                end
                // Next index hits the slot length
                if (word_cnt >= (SIZE_WID-3)'(slot.words))
                begin
                    slot_full <= 1'b1;
                end
            end
        end
    end

    // ====================
    // Status decision
    // ====================

    always_comb
    begin
        if (eop_size < SIZE_WID'(MIN_PKT_SIZE))
        begin
            status_d = STATUS_SHORT;
        end
        else if (eop_size > SIZE_WID'(MAX_PKT_SIZE))
        begin
            status_d = STATUS_LONG;
        end
        else if (slot_full)
        begin
            // eop beat itself fell outside the slot
            status_d = STATUS_OFLOW;
        end
        else if (in_beat.err)
        begin
            status_d = STATUS_ERR;
        end
        else
        begin
            status_d = STATUS_OK;
        end
    end

    assign keep_d = (status_d == STATUS_OK) ||
                    ((status_d == STATUS_ERR) && !DROP_ERRORED);

    // ====================
    // Completion
    // ====================

    // in_rdy drops for the completion cycle only
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_rdy       <= 1'b0;
            evt_valid    <= 1'b0;
            commit_valid <= 1'b0;
            oflow_valid  <= 1'b0;
        end
        else
        begin
            in_rdy       <= !eop_accept;
            evt_valid    <= eop_accept;
            commit_valid <= eop_accept && keep_d;
            oflow_valid  <= eop_accept && (status_d == STATUS_OFLOW);
        end
    end

    always_ff @(posedge clk)
    begin
        if (eop_accept)
        begin
            evt.status   <= status_d;
            evt.size     <= eop_size;
            desc.addr    <= slot.addr;
            desc.size    <= eop_size;
            desc.meta    <= in_beat.meta;
            commit_words <= word_cnt[WORDS_WID-1:0];
        end
    end

    assign desc_valid = commit_valid;

    // Source keeps its beat through the bubble
    a_hold_beat: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid && !in_rdy |=> in_valid && $stable(in_beat)
    ) else $error("packet_write: beat changed while in_rdy low");

    // Slot holds still while a packet is in progress
    a_slot_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (byte_cnt != '0) |-> $stable(slot)
    ) else $error("packet_write: slot changed during a packet");

endmodule

/* design/packet_buffer_mem.sv */
module packet_buffer_mem (
    input  logic                              clk,

    // Write port
    input  logic                              wr_en,
    input  logic [pkt_buf_pkg::ADDR_WID-1:0]  wr_addr,
    input  logic [pkt_buf_pkg::DATA_WID-1:0]  wr_data,

    // Read port, one cycle latency
    input  logic [pkt_buf_pkg::ADDR_WID-1:0]  rd_addr,
    output logic [pkt_buf_pkg::DATA_WID-1:0]  rd_data
);
    import pkt_buf_pkg::*;

    logic [DATA_WID-1:0] mem [BUFFER_WORDS];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/buffer_allocator.sv */
module buffer_allocator (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               commit_valid,
    input  logic [pkt_buf_pkg::WORDS_WID-1:0]  commit_words,
    input  logic                               oflow_valid,
    output pkt_buf_pkg::slot_t                 slot
);
    import pkt_buf_pkg::*;

    logic [ADDR_WID-1:0] head;
    logic [ADDR_WID:0]   words_left;

    // ====================
    // Ring head
    // ====================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            head <= '0;
        end
        else if (oflow_valid)
        begin
            // Tail too short, restart at the bottom
            head <= '0;
        end
        else if (commit_valid)
        begin
            // Wraps modulo BUFFER_WORDS
            head <= head + ADDR_WID'(commit_words);
        end
    end

    // ====================
    // Slot offer
    // ====================

    assign words_left = (ADDR_WID+1)'(BUFFER_WORDS) - {1'b0, head};

    always_comb
    begin
        slot.addr = head;
        if (words_left < (ADDR_WID+1)'(SLOT_WORDS))
        begin
            slot.words = words_left[WORDS_WID-1:0];
        end
        else
        begin
            slot.words = WORDS_WID'(SLOT_WORDS);
        end
    end

    a_commit_oflow_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(commit_valid && oflow_valid)
    ) else $error("buffer_allocator: commit and overflow together");

    // A kept packet never runs past the end of the ring
    a_commit_in_ring: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_valid |-> ({1'b0, head} + (ADDR_WID+1)'(commit_words)
                          <= (ADDR_WID+1)'(BUFFER_WORDS))
    ) else $error("buffer_allocator: commit crosses ring end");

endmodule

/* common/pkt_buf_pkg.sv */
package pkt_buf_pkg;

    // ====================
    // Sizes and limits
    // ====================

    // Memory word geometry
    localparam int DATA_BYTES   = 8;
    localparam int DATA_WID     = DATA_BYTES * 8;
    localparam int BUFFER_WORDS = 512;
    localparam int ADDR_WID     = $clog2(BUFFER_WORDS);

    // Accepted packet length range, in bytes
    localparam int MIN_PKT_SIZE = 16;
    localparam int MAX_PKT_SIZE = 256;

    // Largest slot, max packet rounded up to whole words
    localparam int SLOT_WORDS   = (MAX_PKT_SIZE + DATA_BYTES - 1) / DATA_BYTES;
    localparam int WORDS_WID    = 6;

    // Byte counter, room to count past MAX_PKT_SIZE
    localparam int SIZE_WID     = 12;

    // ====================
    // Types
    // ====================

    typedef enum logic [2:0] {
        STATUS_OK,
        STATUS_ERR,
        STATUS_SHORT,
        STATUS_LONG,
        STATUS_OFLOW
    } pkt_status_t;

    // One input beat, err and meta only meaningful on eop
    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic                eop;
        logic [2:0]          mty;
        logic                err;
        logic [31:0]         meta;
    } pkt_beat_t;

    typedef struct packed {
        logic [ADDR_WID-1:0] addr;
        logic [SIZE_WID-1:0] size;
        logic [31:0]         meta;
    } pkt_desc_t;

    // Slot offered by the allocator
    typedef struct packed {
        logic [ADDR_WID-1:0]  addr;
        logic [WORDS_WID-1:0] words;
    } slot_t;

    typedef struct packed {
        pkt_status_t         status;
        logic [SIZE_WID-1:0] size;
    } pkt_event_t;

endpackage
